// ==== logic/pdp8Pkg.sv ====
// Shared definitions for the 12-bit PDP-8 style core
// Word width, major opcodes, operate microcode bit positions,
// accumulator commands, FSM encodings and the instruction word layout
// Every design file refers to these through pdp8Pkg:: scoped names

package pdp8Pkg;

  // Data and address word
  localparam int wordW = 12;

  // Run always begins here
  localparam logic [wordW-1:0] startAddr = 12'o0200;

  // Major opcodes, bits 11:9 of the instruction
  localparam logic [2:0] opAnd = 3'o0;
  localparam logic [2:0] opTad = 3'o1;
  localparam logic [2:0] opIsz = 3'o2;
  localparam logic [2:0] opDca = 3'o3;
  localparam logic [2:0] opJms = 3'o4;
  localparam logic [2:0] opJmp = 3'o5;
  localparam logic [2:0] opIot = 3'o6;
  localparam logic [2:0] opOpr = 3'o7;

  // Group 1 microcode bits
  localparam int bitCla   = 7;
  localparam int bitCll   = 6;
  localparam int bitCma   = 5;
  localparam int bitCml   = 4;
  localparam int bitRar   = 3;
  localparam int bitRal   = 2;
  localparam int bitTwice = 1;
  localparam int bitIac   = 0;

  // Selects group 2 when set
  localparam int bitGroup = 8;

  // Group 2 microcode bits, CLA shares bit 7 with group 1
  localparam int bitSma = 6;
  localparam int bitSza = 5;
  localparam int bitSnl = 4;
  localparam int bitInv = 3;
  localparam int bitHlt = 1;

  // Commands from the sequencer to the accumulator unit
  localparam int accOpW = 3;
  localparam logic [accOpW-1:0] accNop = 3'd0;
  localparam logic [accOpW-1:0] accAnd = 3'd1;
  localparam logic [accOpW-1:0] accTad = 3'd2;
  localparam logic [accOpW-1:0] accDca = 3'd3;
  localparam logic [accOpW-1:0] accOpr = 3'd4;

  // Memory port FSM
  localparam int mpStateW = 2;
  localparam logic [mpStateW-1:0] mpIdle    = 2'd0;
  localparam logic [mpStateW-1:0] mpReq     = 2'd1;
  localparam logic [mpStateW-1:0] mpRelease = 2'd2;
  localparam logic [mpStateW-1:0] mpFinish  = 2'd3;

  // Major states of the sequencer
  localparam int seqStateW = 3;
  localparam logic [seqStateW-1:0] sIdle      = 3'd0;
  localparam logic [seqStateW-1:0] sFetch     = 3'd1;
  localparam logic [seqStateW-1:0] sDefer     = 3'd2;
  localparam logic [seqStateW-1:0] sExec      = 3'd3;
  localparam logic [seqStateW-1:0] sWriteBack = 3'd4;
  localparam logic [seqStateW-1:0] sOper      = 3'd5;

  // One instruction word seen as memory reference or as operate word
  typedef union packed {
    struct packed {
      logic [2:0] opcode;
      logic       indirect;
      logic       page;
      logic [6:0] offset;
    } memRef;
    struct packed {
      logic [2:0] opcode;
      logic       group;
      logic [7:0] micro;
    } operate;
  } instWord_t;

endpackage

// ==== logic/memReqIf.sv ====
// Request channel between the sequencer and the memory port
// The sequencer pulses start with the access fields stable
// The memory port pulses done when the external cycle is over

`timescale 1ns/1ps

interface memReqIf;

  logic                       start;
  logic                       we;
  logic [pdp8Pkg::wordW-1:0]  addr;
  logic [pdp8Pkg::wordW-1:0]  wdata;
  // Completion and read data, rdata held until the next start
  logic                       done;
  logic [pdp8Pkg::wordW-1:0]  rdata;

  modport requester (output start, we, addr, wdata, input done, rdata);

  modport port (input start, we, addr, wdata, output done, rdata);

endinterface

// ==== logic/accCmdIf.sv ====
// Command channel between the sequencer and the accumulator unit
// op is a one-cycle command, registers update at the end of it
// skip and halt decode the current operate word combinationally

`timescale 1ns/1ps

interface accCmdIf;

  logic [pdp8Pkg::accOpW-1:0] op;
  logic [pdp8Pkg::wordW-1:0]  operand;
  pdp8Pkg::instWord_t         inst;
  // State and decode results back to the sequencer
  logic [pdp8Pkg::wordW-1:0]  acVal;
  logic                       linkVal;
  logic                       skip;
  logic                       halt;

  modport sequencer (output op, operand, inst, input acVal, linkVal, skip, halt);

  modport accumulator (input op, operand, inst, output acVal, linkVal, skip, halt);

endinterface

// ==== logic/memPort.sv ====
// Four-phase req/ack master toward the external memory
// Latches one access on start, holds memReq until memAck,
// then waits for memAck to drop before reporting done

`timescale 1ns/1ps

module memPort (
  input  logic                      clk,
  input  logic                      rst,
  memReqIf.port                     bus,
  output logic                      memReq,
  output logic                      memWe,
  output logic [pdp8Pkg::wordW-1:0] memAddr,
  output logic [pdp8Pkg::wordW-1:0] memWdata,
  input  logic                      memAck,
  input  logic [pdp8Pkg::wordW-1:0] memRdata
);

  logic [pdp8Pkg::mpStateW-1:0] state;
  logic [pdp8Pkg::wordW-1:0]    rdataReg;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= pdp8Pkg::mpIdle;
      memReq <= 1'b0;
      memWe  <= 1'b0;
    end else begin
      case (state)
        pdp8Pkg::mpIdle: if (bus.start) begin
          memReq <= 1'b1;
          memWe  <= bus.we;
          state  <= pdp8Pkg::mpReq;
        end
        // Late memAck simply stretches this state
        pdp8Pkg::mpReq: if (memAck) begin
          memReq <= 1'b0;
          state  <= pdp8Pkg::mpRelease;
        end
        // Memory must release ack before the next request
        pdp8Pkg::mpRelease: if (!memAck) begin
          state <= pdp8Pkg::mpFinish;
        end
        default: state <= pdp8Pkg::mpIdle;
      endcase
    end
  end

  // Address and write data stay put for the whole request
  always_ff @(posedge clk) begin
    if (state == pdp8Pkg::mpIdle && bus.start) begin
      memAddr  <= bus.addr;
      memWdata <= bus.wdata;
    end
    // Read data is valid while ack is high
    if (state == pdp8Pkg::mpReq && memAck) begin
      rdataReg <= memRdata;
    end
  end

  assign bus.rdata = rdataReg;
  // One-cycle completion pulse
  assign bus.done  = (state == pdp8Pkg::mpFinish);

endmodule

// ==== logic/sequencer.sv ====
// Major-state FSM of the core
// Holds PC, IR, effective address and memory data register and
// walks each instruction through fetch, defer, execute and write-back
// PC is advanced when a fetch is issued, so it always points past IR

`timescale 1ns/1ps

module sequencer (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      run,
  memReqIf.requester                mem,
  accCmdIf.sequencer                acc,
  output logic                      halted,
  output logic [pdp8Pkg::wordW-1:0] pc
);

  logic [pdp8Pkg::seqStateW-1:0] state;
  logic [pdp8Pkg::seqStateW-1:0] stateNext;
  logic [pdp8Pkg::wordW-1:0]     pcReg;
  pdp8Pkg::instWord_t            ir;
  pdp8Pkg::instWord_t            curInst;
  logic [pdp8Pkg::wordW-1:0]     ea;
  logic [pdp8Pkg::wordW-1:0]     mdr;
  logic [pdp8Pkg::wordW-1:0]     addrReg;
  logic [pdp8Pkg::wordW-1:0]     wdataReg;
  logic                          weReg;
  logic                          startReg;
  logic [pdp8Pkg::accOpW-1:0]    opReg;
  logic [pdp8Pkg::accOpW-1:0]    opNext;
  // Address forming
  logic [pdp8Pkg::wordW-1:0]     eaCalc;
  logic [pdp8Pkg::wordW-1:0]     eaFinal;
  logic                          isMemRef;
  logic                          eaReady;
  // Access requests for this cycle
  logic                          fetchGo;
  logic [pdp8Pkg::wordW-1:0]     fetchAddr;
  logic                          dataGo;
  logic                          dataWe;
  logic [pdp8Pkg::wordW-1:0]     dataAddr;
  logic [pdp8Pkg::wordW-1:0]     dataWdata;

  // During fetch the new word is still on rdata
  assign curInst = (state == pdp8Pkg::sFetch) ? pdp8Pkg::instWord_t'(mem.rdata) : ir;

  // Page zero or current page, addrReg still holds the fetch address
  assign eaCalc = {curInst.memRef.page ? addrReg[pdp8Pkg::wordW-1:7] : 5'b00000,
                   curInst.memRef.offset};
  // Defer read returns the final address
  assign eaFinal = (state == pdp8Pkg::sDefer) ? mem.rdata : eaCalc;

  assign isMemRef = (curInst.memRef.opcode != pdp8Pkg::opIot) &&
                    (curInst.memRef.opcode != pdp8Pkg::opOpr);
  assign eaReady  = mem.done && isMemRef &&
                    ((state == pdp8Pkg::sFetch && !curInst.memRef.indirect) ||
                     state == pdp8Pkg::sDefer);

  always_comb begin
    stateNext = state;
    opNext    = pdp8Pkg::accNop;
    fetchGo   = 1'b0;
    fetchAddr = pcReg;
    dataGo    = 1'b0;
    dataWe    = 1'b0;
    dataAddr  = ea;
    dataWdata = mdr;
    case (state)
      pdp8Pkg::sIdle: if (run) begin
        fetchGo   = 1'b1;
        fetchAddr = pdp8Pkg::startAddr;
        stateNext = pdp8Pkg::sFetch;
      end
      pdp8Pkg::sFetch: if (mem.done) begin
        if (curInst.memRef.opcode == pdp8Pkg::opOpr) begin
          opNext    = pdp8Pkg::accOpr;
          stateNext = pdp8Pkg::sOper;
        end else if (curInst.memRef.opcode == pdp8Pkg::opIot) begin
          // IOT is a no-op, go straight to the next fetch
          fetchGo = 1'b1;
        end else if (curInst.memRef.indirect) begin
          dataGo    = 1'b1;
          dataAddr  = eaCalc;
          stateNext = pdp8Pkg::sDefer;
        end
      end
      pdp8Pkg::sExec: if (mem.done) begin
        case (ir.memRef.opcode)
          pdp8Pkg::opAnd: opNext = pdp8Pkg::accAnd;
          pdp8Pkg::opTad: opNext = pdp8Pkg::accTad;
          pdp8Pkg::opDca: opNext = pdp8Pkg::accDca;
          default: ;
        endcase
        if (ir.memRef.opcode == pdp8Pkg::opIsz) begin
          // Write the incremented word back
          dataGo    = 1'b1;
          dataWe    = 1'b1;
          dataWdata = mem.rdata + 1'b1;
          stateNext = pdp8Pkg::sWriteBack;
        end else begin
          fetchGo   = 1'b1;
          // JMS continues after the stored return address
          fetchAddr = (ir.memRef.opcode == pdp8Pkg::opJms) ? ea + 1'b1 : pcReg;
          stateNext = pdp8Pkg::sFetch;
        end
      end
      pdp8Pkg::sWriteBack: if (mem.done) begin
        fetchGo   = 1'b1;
        fetchAddr = (mdr == '0) ? pcReg + 1'b1 : pcReg;
        stateNext = pdp8Pkg::sFetch;
      end
      pdp8Pkg::sOper: begin
        // AC and link update at the end of this cycle
        if (acc.halt) begin
          stateNext = pdp8Pkg::sIdle;
        end else begin
          fetchGo   = 1'b1;
          fetchAddr = acc.skip ? pcReg + 1'b1 : pcReg;
          stateNext = pdp8Pkg::sFetch;
        end
      end
      default: ;
    endcase

    // Final address known, start the execute access
    if (eaReady) begin
      case (curInst.memRef.opcode)
        pdp8Pkg::opJmp: begin
          fetchGo   = 1'b1;
          fetchAddr = eaFinal;
          stateNext = pdp8Pkg::sFetch;
        end
        pdp8Pkg::opDca: begin
          dataGo    = 1'b1;
          dataWe    = 1'b1;
          dataAddr  = eaFinal;
          dataWdata = acc.acVal;
          stateNext = pdp8Pkg::sExec;
        end
        pdp8Pkg::opJms: begin
          // PC already holds the return address
          dataGo    = 1'b1;
          dataWe    = 1'b1;
          dataAddr  = eaFinal;
          dataWdata = pcReg;
          stateNext = pdp8Pkg::sExec;
        end
        default: begin
          // AND, TAD and ISZ read their operand
          dataGo    = 1'b1;
          dataAddr  = eaFinal;
          stateNext = pdp8Pkg::sExec;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= pdp8Pkg::sIdle;
      pcReg    <= '0;
      ir       <= '0;
      weReg    <= 1'b0;
      startReg <= 1'b0;
      opReg    <= pdp8Pkg::accNop;
    end else begin
      state    <= stateNext;
      startReg <= fetchGo | dataGo;
      opReg    <= opNext;
      if (fetchGo) begin
        addrReg <= fetchAddr;
        weReg   <= 1'b0;
        pcReg   <= fetchAddr + 1'b1;
      end else if (dataGo) begin
        addrReg  <= dataAddr;
        weReg    <= dataWe;
        wdataReg <= dataWdata;
      end
      if (state == pdp8Pkg::sFetch && mem.done) begin
        ir <= mem.rdata;
      end
    end
  end

  // Address and data registers
  always_ff @(posedge clk) begin
    if (eaReady) begin
      ea <= eaFinal;
    end
    // ISZ keeps the incremented value for the zero test
    if (state == pdp8Pkg::sExec && mem.done) begin
      mdr <= (ir.memRef.opcode == pdp8Pkg::opIsz) ? mem.rdata + 1'b1 : mem.rdata;
    end
  end

  assign mem.start = startReg;
  assign mem.we    = weReg;
  assign mem.addr  = addrReg;
  assign mem.wdata = wdataReg;

  assign acc.op      = opReg;
  assign acc.operand = mdr;
  assign acc.inst    = ir;

  assign halted = (state == pdp8Pkg::sIdle);
  assign pc     = pcReg;

endmodule

// ==== logic/accUnit.sv ====
// Accumulator and link with the AND/TAD datapath
// Group 1 microcode runs as a clear, complement, increment, rotate chain
// Group 2 skip and halt decode combinationally from the current AC

`timescale 1ns/1ps

module accUnit (
  input  logic       clk,
  input  logic       rst,
  accCmdIf.accumulator acc
);

  logic [pdp8Pkg::wordW-1:0] acReg;
  logic [pdp8Pkg::wordW-1:0] acNext;
  logic                      linkReg;
  logic                      linkNext;
  logic [7:0]                micro;
  logic                      isOpr;
  logic                      group1;
  logic                      group2;
  logic                      condHit;
  logic [pdp8Pkg::wordW:0]   tadSum;
  // Group 1 chain
  logic [pdp8Pkg::wordW-1:0] g1Ac;
  logic                      g1Link;
  logic [pdp8Pkg::wordW:0]   incSum;
  logic [pdp8Pkg::wordW:0]   rot;

  assign micro  = acc.inst.operate.micro;
  assign isOpr  = (acc.inst.operate.opcode == pdp8Pkg::opOpr);
  assign group1 = isOpr && !acc.inst[pdp8Pkg::bitGroup];
  // Bit 0 set in a group word means group 3, treated as no-op
  assign group2 = isOpr && acc.inst[pdp8Pkg::bitGroup] && !micro[pdp8Pkg::bitIac];

  always_comb begin
    // Clear first
    g1Ac   = micro[pdp8Pkg::bitCla] ? '0 : acReg;
    g1Link = micro[pdp8Pkg::bitCll] ? 1'b0 : linkReg;
    // Then complement
    if (micro[pdp8Pkg::bitCma]) g1Ac = ~g1Ac;
    if (micro[pdp8Pkg::bitCml]) g1Link = ~g1Link;
    // IAC carry out flips the link
    incSum = {1'b0, g1Ac} + {{pdp8Pkg::wordW{1'b0}}, micro[pdp8Pkg::bitIac]};
    rot    = {g1Link ^ incSum[pdp8Pkg::wordW], incSum[pdp8Pkg::wordW-1:0]};
    // Rotate link and AC as one 13-bit ring
    if (micro[pdp8Pkg::bitRar]) begin
      rot = {rot[0], rot[pdp8Pkg::wordW:1]};
      if (micro[pdp8Pkg::bitTwice]) rot = {rot[0], rot[pdp8Pkg::wordW:1]};
    end else if (micro[pdp8Pkg::bitRal]) begin
      rot = {rot[pdp8Pkg::wordW-1:0], rot[pdp8Pkg::wordW]};
      if (micro[pdp8Pkg::bitTwice]) rot = {rot[pdp8Pkg::wordW-1:0], rot[pdp8Pkg::wordW]};
    end else if (micro[pdp8Pkg::bitTwice]) begin
      // BSW, link untouched
      rot = {rot[pdp8Pkg::wordW], rot[pdp8Pkg::wordW/2-1:0],
             rot[pdp8Pkg::wordW-1:pdp8Pkg::wordW/2]};
    end
  end

  assign tadSum = {1'b0, acReg} + {1'b0, acc.operand};

  always_comb begin
    acNext   = acReg;
    linkNext = linkReg;
    case (acc.op)
      pdp8Pkg::accAnd: acNext = acReg & acc.operand;
      pdp8Pkg::accTad: begin
        acNext   = tadSum[pdp8Pkg::wordW-1:0];
        linkNext = linkReg ^ tadSum[pdp8Pkg::wordW];
      end
      // Memory already holds the old AC
      pdp8Pkg::accDca: acNext = '0;
      pdp8Pkg::accOpr: begin
        if (group1) begin
          {linkNext, acNext} = rot;
        end else if (group2 && micro[pdp8Pkg::bitCla]) begin
          // Group 2 clear comes after the skip test
          acNext = '0;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      acReg   <= '0;
      linkReg <= 1'b0;
    end else begin
      acReg   <= acNext;
      linkReg <= linkNext;
    end
  end

  // OR of the selected conditions, INV turns it into AND of the negations
  assign condHit = (micro[pdp8Pkg::bitSma] && acReg[pdp8Pkg::wordW-1]) ||
                   (micro[pdp8Pkg::bitSza] && (acReg == '0)) ||
                   (micro[pdp8Pkg::bitSnl] && linkReg);

  assign acc.skip    = group2 && (condHit ^ micro[pdp8Pkg::bitInv]);
  assign acc.halt    = group2 && micro[pdp8Pkg::bitHlt];
  assign acc.acVal   = acReg;
  assign acc.linkVal = linkReg;

endmodule

// ==== logic/pdp8Cpu.sv ====
// Top level of the PDP-8 style core
// Memory lives outside and answers a four-phase req/ack handshake
// Pulse run while halted to start at 0200, halted rises after HLT

`timescale 1ns/1ps

module pdp8Cpu (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      run,
  // External memory
  output logic                      memReq,
  output logic                      memWe,
  output logic [pdp8Pkg::wordW-1:0] memAddr,
  output logic [pdp8Pkg::wordW-1:0] memWdata,
  input  logic                      memAck,
  input  logic [pdp8Pkg::wordW-1:0] memRdata,
  // Status
  output logic                      halted,
  output logic [pdp8Pkg::wordW-1:0] ac,
  output logic                      link,
  output logic [pdp8Pkg::wordW-1:0] pc
);

  memReqIf memBus ();
  accCmdIf accBus ();

  memPort port (
    .clk      (clk),
    .rst      (rst),
    .bus      (memBus),
    .memReq   (memReq),
    .memWe    (memWe),
    .memAddr  (memAddr),
    .memWdata (memWdata),
    .memAck   (memAck),
    .memRdata (memRdata)
  );

  sequencer seq (
    .clk    (clk),
    .rst    (rst),
    .run    (run),
    .mem    (memBus),
    .acc    (accBus),
    .halted (halted),
    .pc     (pc)
  );

  accUnit accum (
    .clk (clk),
    .rst (rst),
    .acc (accBus)
  );

  // AC and link are visible for debug and checking
  assign ac   = accBus.acVal;
  assign link = accBus.linkVal;

endmodule

// ==== tests/clockGen.sv ====
// Clock and reset source for the testbench
// 8 ns clock, reset held for 3 cycles at power-up and after each resetReq

`timescale 1ns/1ps

module clockGen (
  input  logic resetReq,
  output logic clk,
  output logic rst
);

  logic [1:0] rstLeft = 2'd2;
  logic       rstReg  = 1'b1;
  logic       reqSeen;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset moves 1 ns after the edge, request sampled on the edge
  always @(posedge clk) begin
    reqSeen = resetReq;
    #1;
    if (reqSeen) rstLeft = 2'd3;
    rstReg = (rstLeft != 2'd0);
    if (rstLeft != 2'd0) rstLeft = rstLeft - 2'd1;
  end

  assign rst = rstReg;

endmodule

// ==== tests/cpuProperties.sv ====
// Handshake and halt rules of the core, bound into every pdp8Cpu
// Watches the external four-phase request and the halted flag

`timescale 1ns/1ps

module cpuProperties (
  input logic        clk,
  input logic        rst,
  input logic        memReq,
  input logic        memAck,
  input logic [11:0] memAddr,
  input logic        halted
);

  // Request holds until memory answers
  reqHeld: assert property (@(posedge clk) disable iff (rst)
    memReq && !memAck |=> memReq)
    else $error("memReq dropped before memAck");

  // Address fixed under an open request
  addrStable: assert property (@(posedge clk) disable iff (rst)
    memReq && !memAck |=> $stable(memAddr))
    else $error("memAddr changed while memReq was high");

  // A halted core starts no access
  noReqHalted: assert property (@(posedge clk) disable iff (rst)
    $rose(memReq) |-> !halted)
    else $error("memReq rose while the core was halted");

endmodule

bind pdp8Cpu cpuProperties props (
  .clk     (clk),
  .rst     (rst),
  .memReq  (memReq),
  .memAck  (memAck),
  .memAddr (memAddr),
  .halted  (halted)
);

// ==== tests/cpuTb.sv ====
// Testbench for the PDP-8 style core
// Owns the 4096-word memory, answers the four-phase handshake with
// random ack delays and runs a table of small programs up to HLT
// Each row is checked on AC, link, halt PC and one memory word

`timescale 1ns/1ps

module cpuTb;

  localparam int numTests  = 6;
  localparam int maxProg   = 8;
  localparam int haltLimit = 2000;

  logic        resetReq;
  logic        run;
  logic        clk;
  logic        rst;
  logic        memReq;
  logic        memWe;
  logic [11:0] memAddr;
  logic [11:0] memWdata;
  logic        memAck   = 1'b0;
  logic [11:0] memRdata = 12'o0;
  logic        halted;
  logic [11:0] ac;
  logic        link;
  logic [11:0] pc;

  logic [11:0] mem [0:4095];
  logic [31:0] lcgState = 32'h0f791c43;
  logic [1:0]  ackDelay;
  logic        ackPending;
  logic        rstSeen;
  int          curRow;
  int          passCount;
  int          failCount;

  // Table, program words packed first word high, data as {addr, value, addr, value}
  string       tName [numTests];
  logic [95:0] tProg [numTests];
  logic [47:0] tData [numTests];
  logic [11:0] tAc   [numTests];
  logic        tLink [numTests];
  logic [11:0] tPc   [numTests];
  // Memory word to check, {addr, value}
  logic [23:0] tMem  [numTests];

  clockGen clkGen (.resetReq(resetReq), .clk(clk), .rst(rst));

  pdp8Cpu dut (
    .clk      (clk),
    .rst      (rst),
    .run      (run),
    .memReq   (memReq),
    .memWe    (memWe),
    .memAddr  (memAddr),
    .memWdata (memWdata),
    .memAck   (memAck),
    .memRdata (memRdata),
    .halted   (halted),
    .ac       (ac),
    .link     (link),
    .pc       (pc)
  );

  // LCG step, top bits give the ack delay in cycles
  function automatic logic [1:0] nextDelay();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState[31:30];
  endfunction

  task automatic loadMemory(input int r);
    logic [11:0] addr;
    for (int a = 0; a < 4096; a++) begin
      mem[a] = 12'(a) ^ 12'o5252;
    end
    for (int i = 0; i < maxProg; i++) begin
      addr = 12'o0200 + 12'(i);
      mem[addr] = tProg[r][95 - 12*i -: 12];
    end
    mem[tData[r][47:36]] = tData[r][35:24];
    mem[tData[r][23:12]] = tData[r][11:0];
  endtask

  // Memory side of the handshake, reloaded while reset is high
  always @(posedge clk) begin
    rstSeen = rst;
    #1;
    if (rstSeen) begin
      memAck     = 1'b0;
      ackPending = 1'b0;
      loadMemory(curRow);
    end else if (memAck) begin
      if (!memReq) memAck = 1'b0;
    end else if (memReq) begin
      if (!ackPending) begin
        ackPending = 1'b1;
        ackDelay   = nextDelay();
      end
      if (ackDelay == 2'd0) begin
        ackPending = 1'b0;
        memAck     = 1'b1;
        if (memWe) mem[memAddr] = memWdata;
        else memRdata = mem[memAddr];
      end else begin
        ackDelay = ackDelay - 2'd1;
      end
    end
  end

  task automatic addTest(input int r, input string name, input logic [95:0] prog,
                         input logic [47:0] data, input logic [11:0] expAc,
                         input logic expLink, input logic [11:0] expPc,
                         input logic [23:0] memChk);
    tName[r] = name;
    tProg[r] = prog;
    tData[r] = data;
    tAc[r]   = expAc;
    tLink[r] = expLink;
    tPc[r]   = expPc;
    tMem[r]  = memChk;
  endtask

  task automatic runTest(input int r);
    int cycles;
    int errs;
    errs   = 0;
    curRow = r;
    @(posedge clk);
    #1;
    resetReq = 1'b1;
    @(posedge clk);
    #1;
    resetReq = 1'b0;
    cycles = 0;
    @(negedge clk);
    while (rst && cycles < 10) begin
      @(negedge clk);
      cycles++;
    end
    @(posedge clk);
    #1;
    run = 1'b1;
    @(posedge clk);
    #1;
    run = 1'b0;
    cycles = 0;
    @(negedge clk);
    while (halted && cycles < 10) begin
      @(negedge clk);
      cycles++;
    end
    if (rst || halted) begin
      $display("%s: core did not leave reset or did not start on run", tName[r]);
      errs++;
    end else begin
      cycles = 0;
      while (!halted && cycles < haltLimit) begin
        @(negedge clk);
        cycles++;
      end
      if (!halted) begin
        $display("%s: core did not halt within %0d cycles", tName[r], haltLimit);
        errs++;
      end else begin
        if (ac !== tAc[r]) begin
          $display("CHECK FAILED at %0d ns: ac is %o, expected %o", $time, ac, tAc[r]);
          errs++;
        end
        if (link !== tLink[r]) begin
          $display("CHECK FAILED at %0d ns: link is %b, expected %b", $time, link, tLink[r]);
          errs++;
        end
        if (pc !== tPc[r]) begin
          $display("CHECK FAILED at %0d ns: pc is %o, expected %o", $time, pc, tPc[r]);
          errs++;
        end
        if (mem[tMem[r][23:12]] !== tMem[r][11:0]) begin
          $display("CHECK FAILED at %0d ns: mem[%o] is %o, expected %o", $time,
                   tMem[r][23:12], mem[tMem[r][23:12]], tMem[r][11:0]);
          errs++;
        end
      end
    end
    if (errs == 0) begin
      passCount++;
      $display("Test %s ok", tName[r]);
    end else begin
      failCount++;
      $display("Test %s failed with %0d errors", tName[r], errs);
    end
  endtask

  initial begin
    resetReq  = 1'b0;
    run       = 1'b0;
    curRow    = 0;
    passCount = 0;
    failCount = 0;
    // 6000 + 3000 carries out, link flips, DCA stores 1000
    addTest(0, "tadSum",
            {12'o1050, 12'o1051, 12'o3052, 12'o1050, 12'o7402, 12'o0, 12'o0, 12'o0},
            {12'o0050, 12'o6000, 12'o0051, 12'o3000},
            12'o6000, 1'b1, 12'o0205, {12'o0052, 12'o1000});
    // CLA CMA then AND I 250, pointer 0300 holds 1234
    addTest(1, "andIndirect",
            {12'o7240, 12'o0650, 12'o7402, 12'o0, 12'o0, 12'o0, 12'o0, 12'o0},
            {12'o0250, 12'o0300, 12'o0300, 12'o1234},
            12'o1234, 1'b0, 12'o0203, {12'o0250, 12'o0300});
    // 7777 wraps and skips the first HLT, 0005 does not skip
    addTest(2, "iszSkip",
            {12'o2060, 12'o7402, 12'o2061, 12'o7402, 12'o0, 12'o0, 12'o0, 12'o0},
            {12'o0060, 12'o7777, 12'o0061, 12'o0005},
            12'o0000, 1'b0, 12'o0204, {12'o0060, 12'o0000});
    // JMS 204 stores 0201, subroutine does IAC and JMP I 204
    addTest(3, "jmsReturn",
            {12'o4204, 12'o7402, 12'o7402, 12'o7402, 12'o0, 12'o7001, 12'o5604, 12'o7402},
            {12'o0100, 12'o0000, 12'o0101, 12'o0000},
            12'o0001, 1'b0, 12'o0202, {12'o0204, 12'o0201});
    // 7777, IAC to 0 with link, RAL 0001, RTR 4000, BSW 0040, CML
    addTest(4, "group1",
            {12'o7340, 12'o7001, 12'o7004, 12'o7012, 12'o7002, 12'o7020, 12'o7402, 12'o0},
            {12'o0100, 12'o0000, 12'o0101, 12'o0000},
            12'o0040, 1'b1, 12'o0207, {12'o0200, 12'o7340});
    // SZA taken, SNL not, SMA taken, SPA SNA SZL not taken
    addTest(5, "group2",
            {12'o7440, 12'o7402, 12'o7420, 12'o7040, 12'o7500, 12'o7402, 12'o7570, 12'o7402},
            {12'o0100, 12'o0000, 12'o0101, 12'o0000},
            12'o7777, 1'b0, 12'o0210, {12'o0200, 12'o7440});
    for (int r = 0; r < numTests; r++) begin
      runTest(r);
    end
    $display("Tests passed: %0d, tests failed: %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
logic/pdp8Pkg.sv
logic/memReqIf.sv
logic/accCmdIf.sv
logic/memPort.sv
logic/sequencer.sv
logic/accUnit.sv
logic/pdp8Cpu.sv
tests/clockGen.sv
tests/cpuProperties.sv
tests/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the PDP-8 core and its testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module cpuTb -f build.f -o cpuSim &&
  ./obj_dir/cpuSim > sim.log 2>&1 ||
  echo "Build or simulation returned an error status"
cat sim.log 2>/dev/null
grep -qx "Verification passed" sim.log && exit 0 || exit 1
